// File: common/cmd_settings.svh
`ifndef CMD_SETTINGS_SVH
`define CMD_SETTINGS_SVH

//////////////////////////////
// stream format

`define CMD_DATA_W 32            // every stream word is full width
`define CMD_CODE_W 5             // command code sits in the low bits of the command word

//////////////////////////////
// command codes

`define CMD_CC_LOOPBACK 1        // echo the payload
`define CMD_CC_RD_REG 2          // read one register
`define CMD_CC_WR_REG 3          // write one register

//////////////////////////////
// register map

`define CMD_REG_COUNT 8          // six read/write, board id, response count
`define CMD_BOARD_ID 32'hfeb0_0a17  // value returned by register 6

`endif

// File: common/cmd_pkg.sv
`include "cmd_settings.svh"

package cmd_pkg;

	//////////////////////////////
	// stream words

	typedef logic [`CMD_DATA_W-1:0] cmd_word_t;   // one word on any of the streams

	localparam int cmd_code_w = `CMD_CODE_W;

	//////////////////////////////
	// command codes

	// codes the executor knows, everything else maps to cc_none
	typedef enum logic [`CMD_CODE_W-1:0] {
		cc_none     = '0,
		cc_loopback = `CMD_CC_LOOPBACK,
		cc_rd_reg   = `CMD_CC_RD_REG,
		cc_wr_reg   = `CMD_CC_WR_REG
	} cmd_code_e;

	// pull the code field out of a command word
	function automatic cmd_code_e cmd_decode(cmd_word_t w);
		case (w[cmd_code_w-1:0])
			`CMD_CC_LOOPBACK: return cc_loopback;
			`CMD_CC_RD_REG:   return cc_rd_reg;
			`CMD_CC_WR_REG:   return cc_wr_reg;
			default:          return cc_none;   // unknown, frame gets drained
		endcase
	endfunction

endpackage

// File: common/reg_pkg.sv
`include "cmd_settings.svh"

package reg_pkg;

	import cmd_pkg::*;

	typedef logic [$clog2(`CMD_REG_COUNT)-1:0] reg_idx_t;   // index into the bank

	// the top two registers are read only
	localparam int reg_rw_count = `CMD_REG_COUNT - 2;
	localparam reg_idx_t reg_id_idx = reg_idx_t'(reg_rw_count);        // board identifier
	localparam reg_idx_t reg_cnt_idx = reg_idx_t'(reg_rw_count + 1);   // responses sent

	// register number as received, full word so that 8 and up are caught
	function automatic logic reg_exists(cmd_word_t num);
		return num < `CMD_REG_COUNT;
	endfunction

	function automatic logic reg_writable(cmd_word_t num);
		return num < reg_rw_count;
	endfunction

endpackage

// File: dispatch/cmd_dispatch.sv
`timescale 1ns/1ps

module cmd_dispatch (
	input  logic               clk,
	input  logic               reset,
	input  cmd_pkg::cmd_word_t rx_data,
	input  logic               rx_tvalid,
	input  logic               rx_tlast,
	output logic               rx_tready,
	output cmd_pkg::cmd_word_t pay_data,     // payload after csn and command
	output logic               pay_valid,
	output logic               pay_last,
	input  logic               pay_ready,
	output logic               start,        // one cycle, kicks off cmd_exec
	output cmd_pkg::cmd_code_e code,
	output cmd_pkg::cmd_word_t csn,
	output cmd_pkg::cmd_word_t cmd,
	input  logic               exec_done,
	output logic               cmd_idle
);

	import cmd_pkg::*;

	typedef enum logic [2:0] {st_idle, st_header, st_payload, st_drain, st_wait} state_t;

	state_t    state;
	logic      rx_xfer;
	cmd_code_e rx_code;                 // code field of the word on rx right now

	assign rx_xfer  = rx_tvalid && rx_tready;
	assign rx_code  = cmd_decode(rx_data);
	assign cmd_idle = (state == st_idle);

	// payload goes straight through, exec back-pressures rx
	assign pay_data = rx_data;
	assign pay_last = rx_tlast;

	always_comb begin
		rx_tready = 1'b0;
		pay_valid = 1'b0;
		case (state)
			st_idle, st_header, st_drain: rx_tready = 1'b1;
			st_payload: begin
				rx_tready = pay_ready;
				pay_valid = rx_tvalid;
			end
			default: rx_tready = 1'b0;     // st_wait holds off the next frame
		endcase
	end

	//////////////////////////////
	// frame sequencing

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			start <= 1'b0;
			code  <= cc_none;
		end else begin
			start <= 1'b0;
			case (state)
				st_idle:
					if (rx_xfer && !rx_tlast) state <= st_header;  // csn alone is dropped
				st_header:
					if (rx_xfer) begin
						code <= rx_code;
						if (rx_tlast)
							state <= st_idle;         // no payload, nothing to run
						else if (rx_code == cc_none)
							state <= st_drain;        // unknown code, swallow the rest
						else begin
							start <= 1'b1;
							state <= st_payload;
						end
					end
				st_payload:
					if (rx_xfer && rx_tlast) state <= st_wait;
				st_drain:
					if (rx_xfer && rx_tlast) state <= st_idle;
				st_wait:
					if (exec_done) state <= st_idle;  // response fully handed to tx
				default: state <= st_idle;
			endcase
		end
	end

	// header words held for the whole command
	always_ff @(posedge clk) begin
		if (state == st_idle && rx_xfer) csn <= rx_data;
		if (state == st_header && rx_xfer) cmd <= rx_data;
	end

endmodule

// File: verilog/cmd_exec.sv
`timescale 1ns/1ps

module cmd_exec (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  cmd_pkg::cmd_code_e code,         // held by dispatch until the next frame
	input  cmd_pkg::cmd_word_t csn,
	input  cmd_pkg::cmd_word_t cmd,
	input  cmd_pkg::cmd_word_t pay_data,
	input  logic               pay_valid,
	input  logic               pay_last,
	output logic               pay_ready,
	output cmd_pkg::cmd_word_t resp_data,
	output logic               resp_valid,
	output logic               resp_last,
	input  logic               resp_ready,
	output logic               exec_done,
	output reg_pkg::reg_idx_t  reg_num,
	output logic               reg_wr_en,
	output cmd_pkg::cmd_word_t reg_wr_data,
	input  cmd_pkg::cmd_word_t reg_rd_data
);

	import cmd_pkg::*;
	import reg_pkg::*;

	typedef enum logic [3:0] {
		ex_idle,
		ex_csn,     // echo serial number
		ex_cmd,     // echo command word
		ex_loop,    // loopback payload pass-through
		ex_num,     // take register number
		ex_data,    // take write data
		ex_skip,    // extra payload words are ignored
		ex_val,     // register value
		ex_inv      // inverted command closes the frame
	} ex_state_t;

	ex_state_t state;
	cmd_word_t num_q;                   // register number as received
	cmd_word_t num_now;
	logic      pay_xfer;
	logic      resp_xfer;
	logic      rd_hit;                  // read of an existing register

	assign pay_xfer  = pay_valid && pay_ready;
	assign resp_xfer = resp_valid && resp_ready;

	// in ex_num the number is still on the payload bus
	assign num_now = (state == ex_num) ? pay_data : num_q;
	assign rd_hit  = (code == cc_rd_reg) && reg_exists(num_now);

	//////////////////////////////
	// register access

	assign reg_num     = num_q[$bits(reg_idx_t)-1:0];
	assign reg_wr_data = pay_data;
	assign reg_wr_en   = (state == ex_data) && pay_valid && reg_writable(num_q);  // illegal writes dropped

	always_comb begin
		resp_data  = csn;
		resp_valid = 1'b0;
		resp_last  = 1'b0;
		pay_ready  = 1'b0;
		case (state)
			ex_csn: resp_valid = 1'b1;
			ex_cmd: begin
				resp_data  = cmd;
				resp_valid = 1'b1;
			end
			ex_loop: begin
				resp_data  = pay_data;       // echo, tx back-pressure reaches rx
				resp_valid = pay_valid;
				resp_last  = pay_last;
				pay_ready  = resp_ready;
			end
			ex_num, ex_data, ex_skip: pay_ready = 1'b1;
			ex_val: begin
				resp_data  = reg_rd_data;
				resp_valid = 1'b1;
			end
			ex_inv: begin
				resp_data  = ~cmd;
				resp_valid = 1'b1;
				resp_last  = 1'b1;
			end
			default: resp_valid = 1'b0;
		endcase
	end

	//////////////////////////////
	// response sequencing

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ex_idle;
			exec_done <= 1'b0;
		end else begin
			exec_done <= resp_xfer && resp_last;   // tells dispatch the next frame may come
			case (state)
				ex_idle: if (start) state <= ex_csn;
				ex_csn:  if (resp_ready) state <= ex_cmd;
				ex_cmd:  if (resp_ready) state <= (code == cc_loopback) ? ex_loop : ex_num;
				ex_loop: if (pay_xfer && pay_last) state <= ex_idle;
				ex_num:
					if (pay_valid) begin
						if (pay_last)
							state <= rd_hit ? ex_val : ex_inv;
						else
							state <= (code == cc_wr_reg) ? ex_data : ex_skip;
					end
				ex_data: if (pay_valid) state <= pay_last ? ex_inv : ex_skip;
				ex_skip: if (pay_valid && pay_last) state <= rd_hit ? ex_val : ex_inv;
				ex_val:  if (resp_ready) state <= ex_inv;
				ex_inv:  if (resp_ready) state <= ex_idle;
				default: state <= ex_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ex_num && pay_valid) num_q <= pay_data;
	end

endmodule

// File: verilog/reg_bank.sv
`timescale 1ns/1ps
`include "cmd_settings.svh"

module reg_bank (
	input  logic               clk,
	input  logic               reset,
	input  reg_pkg::reg_idx_t  reg_num,
	input  logic               reg_wr_en,     // only raised for writable numbers
	input  cmd_pkg::cmd_word_t reg_wr_data,
	output cmd_pkg::cmd_word_t reg_rd_data,
	input  logic               frame_sent     // one per response frame on tx
);

	import cmd_pkg::*;
	import reg_pkg::*;

	cmd_word_t rw_regs [reg_rw_count];   // registers 0 to 5
	cmd_word_t resp_cnt;                 // register 7, wraps

	//////////////////////////////
	// writable registers

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_rw_count; i++)
				rw_regs[i] <= '0;
		end else if (reg_wr_en && reg_num < reg_rw_count) begin
			rw_regs[reg_num] <= reg_wr_data;
		end
	end

	// response counter
	always_ff @(posedge clk) begin
		if (reset)
			resp_cnt <= '0;
		else if (frame_sent)
			resp_cnt <= resp_cnt + 1'b1;
	end

	//////////////////////////////
	// read mux

	always_comb begin
		if (reg_num == reg_id_idx)
			reg_rd_data = `CMD_BOARD_ID;            // fixed board id
		else if (reg_num == reg_cnt_idx)
			reg_rd_data = resp_cnt;
		else
			reg_rd_data = rw_regs[reg_num];
	end

endmodule

// File: verilog/resp_tx.sv
`timescale 1ns/1ps

module resp_tx (
	input  logic               clk,
	input  logic               reset,
	// response words from exec
	input  cmd_pkg::cmd_word_t resp_data,
	input  logic               resp_valid,
	input  logic               resp_last,
	output logic               resp_ready,
	// transmit stream
	output cmd_pkg::cmd_word_t tx_data,
	output logic               tx_tvalid,
	output logic               tx_tlast,
	input  logic               tx_tready,
	output logic               frame_sent
);

	logic tx_xfer;
	logic load;

	//////////////////////////////
	// one-word holding register

	assign tx_xfer    = tx_tvalid && tx_tready;
	assign resp_ready = !tx_tvalid || tx_tready;   // empty, or emptying this cycle
	assign load       = resp_valid && resp_ready;

	// a frame counts once its last word has left on tx
	assign frame_sent = tx_xfer && tx_tlast;

	always_ff @(posedge clk) begin
		if (reset)
			tx_tvalid <= 1'b0;
		else if (load)
			tx_tvalid <= 1'b1;
		else if (tx_xfer)
			tx_tvalid <= 1'b0;    // drained with nothing behind it
	end

	// data and last only move on a load, so they hold while stalled
	always_ff @(posedge clk) begin
		if (load) begin
			tx_data  <= resp_data;
			tx_tlast <= resp_last;
		end
	end

endmodule

// File: verilog/cmd_top.sv
`timescale 1ns/1ps

module cmd_top (
	input  logic              clk,
	input  logic              reset,
	// receive stream, command frames
	input  cmd_pkg::cmd_word_t rx_data,
	input  logic              rx_tvalid,
	input  logic              rx_tlast,
	output logic              rx_tready,
	// transmit stream, response frames
	output cmd_pkg::cmd_word_t tx_data,
	output logic              tx_tvalid,
	output logic              tx_tlast,
	input  logic              tx_tready,
	output logic              cmd_idle      // front panel status
);

	import cmd_pkg::*;
	import reg_pkg::*;

	//////////////////////////////
	// dispatch to exec

	cmd_word_t pay_data;
	logic      pay_valid, pay_last, pay_ready;
	logic      start, exec_done;
	cmd_code_e code;
	cmd_word_t csn, cmd;

	//////////////////////////////
	// exec to bank and tx

	cmd_word_t resp_data;
	logic      resp_valid, resp_last, resp_ready;
	reg_idx_t  reg_num;
	logic      reg_wr_en;
	cmd_word_t reg_wr_data, reg_rd_data;
	logic      frame_sent;           // last tx word went out

	cmd_dispatch u_dispatch (
		.clk(clk), .reset(reset),
		.rx_data(rx_data), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tready(rx_tready),
		.pay_data(pay_data), .pay_valid(pay_valid), .pay_last(pay_last), .pay_ready(pay_ready),
		.start(start), .code(code), .csn(csn), .cmd(cmd),
		.exec_done(exec_done), .cmd_idle(cmd_idle)
	);

	cmd_exec u_exec (
		.clk(clk), .reset(reset),
		.start(start), .code(code), .csn(csn), .cmd(cmd),
		.pay_data(pay_data), .pay_valid(pay_valid), .pay_last(pay_last), .pay_ready(pay_ready),
		.resp_data(resp_data), .resp_valid(resp_valid), .resp_last(resp_last),
		.resp_ready(resp_ready), .exec_done(exec_done),
		.reg_num(reg_num), .reg_wr_en(reg_wr_en), .reg_wr_data(reg_wr_data),
		.reg_rd_data(reg_rd_data)
	);

	reg_bank u_regs (
		.clk(clk), .reset(reset),
		.reg_num(reg_num), .reg_wr_en(reg_wr_en), .reg_wr_data(reg_wr_data),
		.reg_rd_data(reg_rd_data), .frame_sent(frame_sent)
	);

	resp_tx u_tx (
		.clk(clk), .reset(reset),
		.resp_data(resp_data), .resp_valid(resp_valid), .resp_last(resp_last),
		.resp_ready(resp_ready),
		.tx_data(tx_data), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready),
		.frame_sent(frame_sent)
	);

endmodule

// File: test/cmd_assert_chk.sv
`timescale 1ns/1ps

module cmd_assert_chk (
	input logic               clk,
	input logic               reset,
	input cmd_pkg::cmd_word_t s_data,     // watched stream
	input logic               s_valid,
	input logic               s_last,
	input logic               s_ready,
	input logic               busy_start, // command handed to exec
	input logic               busy_end,   // exec finished its response
	input logic               busy_ready  // ready that must stay low while busy
);

	int   fail_count = 0;
	logic in_flight;                      // between start and done
	logic frame_in;                       // whole frame taken, waiting on done

	always_ff @(posedge clk) begin
		if (reset) begin
			in_flight <= 1'b0;
			frame_in  <= 1'b0;
		end else begin
			if (busy_start)
				in_flight <= 1'b1;
			else if (busy_end)
				in_flight <= 1'b0;
			if (busy_end)
				frame_in <= 1'b0;
			else if (in_flight && s_valid && s_ready && s_last)
				frame_in <= 1'b1;     // last payload word taken
		end
	end

	//////////////////////////////
	// stream rules

	// a stalled word keeps its data and last
	stall_hold: assert property (@(posedge clk) disable iff (reset)
		s_valid && !s_ready |=> s_valid && $stable(s_data) && $stable(s_last))
		else begin
			$error("stream word changed or vanished while stalled");
			fail_count++;
		end

	// next frame held off until exec is done
	held_off: assert property (@(posedge clk) disable iff (reset)
		frame_in |-> !busy_ready)
		else begin
			$error("receive ready raised before the command finished");
			fail_count++;
		end

endmodule

//////////////////////////////
// attach to the two stream ends

bind resp_tx cmd_assert_chk u_chk (
	.clk(clk), .reset(reset),
	.s_data(tx_data), .s_valid(tx_tvalid), .s_last(tx_tlast), .s_ready(tx_tready),
	.busy_start(1'b0), .busy_end(1'b0), .busy_ready(1'b0)
);

bind cmd_dispatch cmd_assert_chk u_chk (
	.clk(clk), .reset(reset),
	.s_data(rx_data), .s_valid(rx_tvalid), .s_last(rx_tlast), .s_ready(rx_tready),
	.busy_start(start), .busy_end(exec_done), .busy_ready(rx_tready)
);

// File: test/cmd_scoreboard.sv
`timescale 1ns/1ps
`include "cmd_settings.svh"

module cmd_scoreboard (
	input  logic               clk,
	input  logic               reset,
	input  cmd_pkg::cmd_word_t rx_data,
	input  logic               rx_tvalid,
	input  logic               rx_tlast,
	input  logic               rx_tready,
	input  cmd_pkg::cmd_word_t tx_data,
	input  logic               tx_tvalid,
	input  logic               tx_tlast,
	input  logic               tx_tready,
	input  logic               cmd_idle,
	output int                 error_count,
	output int                 words_checked,
	output int                 resp_checked,   // complete response frames seen
	output int                 pending         // predicted words not yet seen
);

	import cmd_pkg::*;

	localparam int rw_count = `CMD_REG_COUNT - 2;

	cmd_word_t rx_frame [$];            // words of the frame on rx so far
	cmd_word_t exp_data [$];
	logic      exp_last [$];
	cmd_word_t model_regs [rw_count];
	cmd_word_t frames_answered;         // model of register 7

	task automatic expect_word(input cmd_word_t d, input logic last);
		exp_data.push_back(d);
		exp_last.push_back(last);
	endtask

	//////////////////////////////
	// prediction from rx

	task automatic take_rx_word();
		int                     n;
		cmd_word_t              cmd;
		cmd_word_t              num;
		logic [`CMD_CODE_W-1:0] code;
		n = rx_frame.size();
		if (n < 2)
			return;                     // serial number alone says nothing yet
		cmd  = rx_frame[1];
		code = cmd[`CMD_CODE_W-1:0];
		if (code != `CMD_CC_LOOPBACK && code != `CMD_CC_RD_REG && code != `CMD_CC_WR_REG)
			return;                     // unknown code, silently drained
		if (n == 2) begin
			if (!rx_tlast) begin        // header-only frames get no answer
				expect_word(rx_frame[0], 1'b0);
				expect_word(cmd, 1'b0);
			end
			return;
		end
		if (code == `CMD_CC_LOOPBACK)
			expect_word(rx_data, rx_tlast);   // echo word by word
		if (!rx_tlast)
			return;
		num = rx_frame[2];
		if (code == `CMD_CC_RD_REG) begin
			if (num < rw_count)
				expect_word(model_regs[num], 1'b0);
			else if (num == rw_count)
				expect_word(`CMD_BOARD_ID, 1'b0);
			else if (num == rw_count + 1)
				expect_word(frames_answered, 1'b0);  // responses before this one
			expect_word(~cmd, 1'b1);
		end else if (code == `CMD_CC_WR_REG) begin
			expect_word(~cmd, 1'b1);
			if (num < rw_count && n > 3)
				model_regs[num] = rx_frame[3];     // read-only or missing stays put
		end
		frames_answered++;
	endtask

	//////////////////////////////
	// compare tx

	task automatic check_word();
		cmd_word_t d;
		logic      l;
		if (exp_data.size() == 0) begin
			error_count++;
			$display("at %0t: tx word %h arrived with no response outstanding", $time, tx_data);
			return;
		end
		d = exp_data.pop_front();
		l = exp_last.pop_front();
		words_checked++;
		if (tx_data !== d) begin
			error_count++;
			$display("mismatch at %0t: tx_data got %h expected %h", $time, tx_data, d);
		end
		if (tx_tlast !== l) begin
			error_count++;
			$display("mismatch at %0t: tx_tlast got %b expected %b", $time, tx_tlast, l);
		end
		if (l)
			resp_checked++;
	endtask

	// busy from the serial number on, high again once no frame and no response is left
	task automatic check_idle();
		if (rx_frame.size() != 0 && cmd_idle !== 1'b0) begin
			error_count++;
			$display("mismatch at %0t: cmd_idle got %b expected 0", $time, cmd_idle);
		end else if (rx_frame.size() == 0 && pending == 0 && cmd_idle !== 1'b1) begin
			error_count++;
			$display("mismatch at %0t: cmd_idle got %b expected 1", $time, cmd_idle);
		end
	endtask

	initial begin
		error_count   = 0;
		words_checked = 0;
		resp_checked  = 0;
		pending       = 0;
	end

	always @(posedge clk) begin
		if (reset) begin
			rx_frame.delete();
			exp_data.delete();
			exp_last.delete();
			for (int i = 0; i < rw_count; i++)
				model_regs[i] = '0;
			frames_answered = '0;
		end else begin
			if (tx_tvalid && tx_tready)
				check_word();
			check_idle();               // pending still from the edge before
			if (rx_tvalid && rx_tready) begin
				rx_frame.push_back(rx_data);
				take_rx_word();
				if (rx_tlast)
					rx_frame.delete();
			end
		end
		pending = exp_data.size();
	end

endmodule

// File: test/cmd_tb.sv
`timescale 1ns/1ps
`include "cmd_settings.svh"

module cmd_tb;

	import cmd_pkg::*;

	localparam int frame_total    = 200;
	localparam int timeout_cycles = frame_total * 30;

	logic        clk;
	logic        reset;
	cmd_word_t   rx_data;
	logic        rx_tvalid, rx_tlast, rx_tready;
	cmd_word_t   tx_data;
	logic        tx_tvalid, tx_tlast, tx_tready;
	logic        cmd_idle;
	int          sb_errors, words_checked, resp_checked, pending;
	logic [31:0] lfsr;
	int          cycle_count = 0;
	int          frames_sent;
	cmd_word_t   frame [$];

	cmd_top u_dut (
		.clk(clk), .reset(reset),
		.rx_data(rx_data), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tready(rx_tready),
		.tx_data(tx_data), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready),
		.cmd_idle(cmd_idle)
	);

	cmd_scoreboard u_sb (
		.clk(clk), .reset(reset),
		.rx_data(rx_data), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tready(rx_tready),
		.tx_data(tx_data), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready),
		.cmd_idle(cmd_idle),
		.error_count(sb_errors), .words_checked(words_checked),
		.resp_checked(resp_checked), .pending(pending)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;    // 100 ns period

	//////////////////////////////
	// random source

	// fibonacci taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// one clock, then new tx back-pressure
	task automatic next_cycle();
		logic [31:0] r;
		@(posedge clk);
		#1;
		take_bits(2, r);
		tx_tready = (r[1:0] != 2'd0);   // stalls about one cycle in four
	endtask

	task automatic send_word(input cmd_word_t d, input logic last);
		logic [31:0] r;
		logic        taken;
		take_bits(2, r);
		while (r[1:0] == 2'd0) begin    // random gap before the word
			rx_tvalid = 1'b0;
			next_cycle();
			take_bits(2, r);
		end
		rx_data   = d;
		rx_tlast  = last;
		rx_tvalid = 1'b1;
		taken     = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = rx_tready;          // mid cycle, settled
			next_cycle();
		end
		rx_tvalid = 1'b0;
	endtask

	//////////////////////////////
	// frame builder

	task automatic build_frame();
		logic [31:0]            r;
		logic [31:0]            kind;
		logic [31:0]            len;
		logic [`CMD_CODE_W-1:0] code;
		frame.delete();
		take_bits(32, r);
		frame.push_back(r);                         // csn
		take_bits(3, kind);
		take_bits(`CMD_DATA_W - `CMD_CODE_W, r);    // upper bits of the command word
		case (kind)
			0, 1: code = `CMD_CC_LOOPBACK;
			2, 3, 7: code = `CMD_CC_RD_REG;
			4, 5: code = `CMD_CC_WR_REG;
			default: begin
				take_bits(`CMD_CODE_W, len);
				code = len[`CMD_CODE_W-1:0];
				if (code >= 1 && code <= 3)
					code = code + 4;                    // keep it unknown
			end
		endcase
		frame.push_back((r << `CMD_CODE_W) | code);
		if (code == `CMD_CC_RD_REG || code == `CMD_CC_WR_REG) begin
			take_bits(4, r);
			frame.push_back(r % 10);                    // 8 and 9 do not exist
			if (code == `CMD_CC_WR_REG) begin
				take_bits(32, r);
				frame.push_back(r);
			end
		end else begin
			take_bits(2, len);                          // 1 to 4 payload words
			for (int i = 0; i <= len; i++) begin
				take_bits(32, r);
				frame.push_back(r);
			end
		end
	endtask

	//////////////////////////////
	// report

	function automatic int chk_errors();
		return u_dut.u_tx.u_chk.fail_count + u_dut.u_dispatch.u_chk.fail_count;
	endfunction

	task automatic print_summary();
		int chk;
		chk = chk_errors();
		$display("errors %0d (scoreboard %0d, assertions %0d) frames %0d responses %0d words %0d",
			sb_errors + chk, sb_errors, chk, frames_sent, resp_checked, words_checked);
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			$display("timeout after %0d cycles with responses still outstanding", timeout_cycles);
			print_summary();
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		lfsr        = 32'hfe59bfa3;
		reset       = 1'b1;
		rx_data     = '0;
		rx_tvalid   = 1'b0;
		rx_tlast    = 1'b0;
		tx_tready   = 1'b0;
		frames_sent = 0;
		repeat (2) @(posedge clk);
		#1;
		reset     = 1'b0;
		tx_tready = 1'b1;
		for (int f = 0; f < frame_total; f++) begin
			build_frame();
			for (int i = 0; i < frame.size(); i++)
				send_word(frame[i], i == frame.size() - 1);
			frames_sent++;
		end
		while (pending != 0 || !cmd_idle || tx_tvalid)   // drain the last response
			next_cycle();
		repeat (4) next_cycle();
		print_summary();
		if (sb_errors + chk_errors() == 0 && resp_checked > 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: src.f
+incdir+common
common/cmd_pkg.sv
common/reg_pkg.sv
dispatch/cmd_dispatch.sv
verilog/cmd_exec.sv
verilog/reg_bank.sv
verilog/resp_tx.sv
verilog/cmd_top.sv
test/cmd_assert_chk.sv
test/cmd_scoreboard.sv
test/cmd_tb.sv

// File: run.sh
#!/bin/sh
# build the simulator from the file list, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module cmd_tb -o cmd_sim \
	&& ./obj_dir/cmd_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1
